// File: Makefile
TOP := tb_fedp_unit

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f sources.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: fedp_int.sv
`timescale 1ns/1ns

module fedp_int (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            enable,
    fedp_req_if.dst         req,
    output tcu_pkg::word_t  d_val
);
    import tcu_pkg::*;

    // first node index of a tree level, leaves at zero
    function automatic int level_base(input int lvl);
        return 2 * NUM_LANES - ((2 * NUM_LANES) >> lvl);
    endfunction

    logic [2:0]        fmt_q_raw;
    int_fmt_e          fmt_q;
    logic [PROD_W-1:0] lane_prod [NUM_LANES];
    logic [RED_W-1:0]  tree_node [2*NUM_LANES-1];
    logic [RED_W-1:0]  tree_root;
    word_t             c_q;
    word_t             acc_sum;

    if (FEDP_LATENCY != MUL_LATENCY + LEVELS * ADD_LATENCY + ADD_LATENCY ||
        (1 << LEVELS) != NUM_LANES) begin : g_config_check
        $error("fedp_int: lane count or stage latencies inconsistent");
    end

    // format rides along with stage one
    pipe_register #(
        .DATAW (3),
        .DEPTH (MUL_LATENCY - 1)
    ) u_fmt_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .data_in  (req.fmt),
        .data_out (fmt_q_raw)
    );

    assign fmt_q = int_fmt_e'(fmt_q_raw);

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        fedp_lane_mult u_lane (
            .clk     (clk),
            .rst_n   (rst_n),
            .enable  (enable),
            .fmt_sel (fmt_q),
            .a_word  (req.a_row[i]),
            .b_word  (req.b_col[i]),
            .product (lane_prod[i])
        );

        // leaves of the tree, sign-extended
        assign tree_node[i] = {{LEVELS{lane_prod[i][PROD_W-1]}}, lane_prod[i]};
    end

    // registered pairwise reduction, one level per cycle
    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
        for (genvar i = 0; i < (NUM_LANES >> (lvl + 1)); i++) begin : g_node
            logic [RED_W-1:0] pair_sum;

            assign pair_sum = tree_node[level_base(lvl) + 2*i]
                            + tree_node[level_base(lvl) + 2*i + 1];

            pipe_register #(
                .DATAW (RED_W),
                .DEPTH (ADD_LATENCY)
            ) u_node (
                .clk      (clk),
                .rst_n    (rst_n),
                .enable   (enable),
                .data_in  (pair_sum),
                .data_out (tree_node[level_base(lvl + 1) + i])
            );
        end
    end

    assign tree_root = tree_node[2*NUM_LANES-2];

    // c waits for the multiply and the tree
    pipe_register #(
        .DATAW ($bits(word_t)),
        .DEPTH (MUL_LATENCY + RED_LATENCY)
    ) u_c_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .data_in  (req.c_val),
        .data_out (c_q)
    );

    // wraps modulo 2^32
    assign acc_sum = {{($bits(word_t) - RED_W){tree_root[RED_W-1]}}, tree_root} + c_q;

    pipe_register #(
        .DATAW ($bits(word_t)),
        .DEPTH (ADD_LATENCY)
    ) u_acc_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .data_in  (acc_sum),
        .data_out (d_val)
    );

endmodule

// File: fedp_lane_mult.sv
`timescale 1ns/1ns

module fedp_lane_mult (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        enable,
    input  tcu_pkg::int_fmt_e           fmt_sel,
    input  tcu_pkg::word_t              a_word,
    input  tcu_pkg::word_t              b_word,
    output logic [tcu_pkg::PROD_W-1:0]  product
);
    import tcu_pkg::*;

    // two signed byte products of a half-word
    function automatic logic signed [16:0] dot2_i8(input logic [15:0] a, input logic [15:0] b);
        return $signed(a[7:0]) * $signed(b[7:0])
             + $signed(a[15:8]) * $signed(b[15:8]);
    endfunction

    function automatic logic [16:0] dot2_u8(input logic [15:0] a, input logic [15:0] b);
        return a[7:0] * b[7:0] + a[15:8] * b[15:8];
    endfunction

    // four signed nibble products of a half-word
    function automatic logic signed [9:0] dot4_i4(input logic [15:0] a, input logic [15:0] b);
        return ($signed(a[3:0]) * $signed(b[3:0]) + $signed(a[7:4]) * $signed(b[7:4]))
             + ($signed(a[11:8]) * $signed(b[11:8]) + $signed(a[15:12]) * $signed(b[15:12]));
    endfunction

    function automatic logic [9:0] dot4_u4(input logic [15:0] a, input logic [15:0] b);
        return (a[3:0] * b[3:0] + a[7:4] * b[7:4])
             + (a[11:8] * b[11:8] + a[15:12] * b[15:12]);
    endfunction

    logic signed [16:0] i8_lo_q;
    logic signed [16:0] i8_hi_q;
    logic [16:0]        u8_lo_q;
    logic [16:0]        u8_hi_q;
    logic signed [9:0]  i4_lo_q;
    logic signed [9:0]  i4_hi_q;
    logic [9:0]         u4_lo_q;
    logic [9:0]         u4_hi_q;
    logic signed [17:0] sum_i8;
    logic [17:0]        sum_u8;
    logic signed [10:0] sum_i4;
    logic [10:0]        sum_u4;
    logic [PROD_W-1:0]  product_d;

    // stage one, all formats computed in parallel
    always_ff @(posedge clk) begin
        if (enable) begin
            i8_lo_q <= dot2_i8(a_word[15:0], b_word[15:0]);
            i8_hi_q <= dot2_i8(a_word[31:16], b_word[31:16]);
            u8_lo_q <= dot2_u8(a_word[15:0], b_word[15:0]);
            u8_hi_q <= dot2_u8(a_word[31:16], b_word[31:16]);
            i4_lo_q <= dot4_i4(a_word[15:0], b_word[15:0]);
            i4_hi_q <= dot4_i4(a_word[31:16], b_word[31:16]);
            u4_lo_q <= dot4_u4(a_word[15:0], b_word[15:0]);
            u4_hi_q <= dot4_u4(a_word[31:16], b_word[31:16]);
        end
    end

    // join the halves
    assign sum_i8 = i8_lo_q + i8_hi_q;
    assign sum_u8 = u8_lo_q + u8_hi_q;
    assign sum_i4 = i4_lo_q + i4_hi_q;
    assign sum_u4 = u4_lo_q + u4_hi_q;

    // unsigned sums get a zero guard bit so the tree can treat all as signed
    always_comb begin
        case (fmt_sel)
            FMT_I8:  product_d = {{(PROD_W-18){sum_i8[17]}}, sum_i8};
            FMT_U8:  product_d = {{(PROD_W-18){1'b0}}, sum_u8};
            FMT_I4:  product_d = {{(PROD_W-11){sum_i4[10]}}, sum_i4};
            FMT_U4:  product_d = {{(PROD_W-11){1'b0}}, sum_u4};
            default: product_d = '0;
        endcase
    end

    pipe_register #(
        .DATAW (PROD_W),
        .DEPTH (MUL_LATENCY - 1)
    ) u_sel_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .data_in  (product_d),
        .data_out (product)
    );

    // the delayed format must be legal once it has been loaded
    fmt_sel_legal_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (enable && $past(enable) && $past(rst_n))
            |-> fmt_sel inside {FMT_I8, FMT_U8, FMT_I4, FMT_U4}
    );

endmodule

// File: fedp_req_if.sv
`timescale 1ns/1ns

interface fedp_req_if;
    import tcu_pkg::*;

    // one dot-product request, sampled on enabled edges
    int_fmt_e                  fmt;
    word_t [NUM_LANES-1:0]     a_row;
    word_t [NUM_LANES-1:0]     b_col;
    word_t                     c_val;

    modport src (
        output fmt,
        output a_row,
        output b_col,
        output c_val
    );

    modport dst (
        input fmt,
        input a_row,
        input b_col,
        input c_val
    );

endinterface

// File: pipe_register.sv
`timescale 1ns/1ns

module pipe_register #(
    parameter int DATAW = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             enable,
    input  logic [DATAW-1:0] data_in,
    output logic [DATAW-1:0] data_out
);

    if (DEPTH == 0) begin : g_bypass
        assign data_out = data_in;
    end else begin : g_chain
        logic [DATAW-1:0] stage_q [DEPTH];

        // whole chain shifts together, holds while stalled
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                for (int i = 0; i < DEPTH; i++) begin
                    stage_q[i] <= '0;
                end
            end else if (enable) begin
                stage_q[0] <= data_in;
                for (int i = 1; i < DEPTH; i++) begin
                    stage_q[i] <= stage_q[i-1];
                end
            end
        end

        assign data_out = stage_q[DEPTH-1];
    end

endmodule

// File: sources.f
tcu_pkg.sv
fedp_req_if.sv
pipe_register.sv
fedp_lane_mult.sv
fedp_int.sv
tcu_fedp_unit.sv
tb_fedp_unit.sv

// File: tb_fedp_unit.sv
`timescale 1ns/1ns

module tb_fedp_unit;
    import tcu_pkg::*;

    localparam int NUM_PER_FMT   = 50;
    localparam int NUM_EXTREME   = 7;
    localparam int NUM_STALL_REQ = 100;
    localparam int NUM_REQ       = 4 * NUM_PER_FMT + NUM_EXTREME + 1 + NUM_STALL_REQ;
    localparam int CYCLE_LIMIT   = NUM_REQ * 3 + 200;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  enable;
    logic                  valid_in;
    int_fmt_e              fmt;
    word_t [NUM_LANES-1:0] a_row;
    word_t [NUM_LANES-1:0] b_col;
    word_t                 c_val;
    logic                  valid_out;
    word_t                 d_val;

    logic [31:0] lcg_state = 32'h1beb_831f;
    word_t       expected_q [$];
    int          pass_count;
    int          fail_count;
    int          cycle_count;
    int_fmt_e    fmt_list [4] = '{FMT_I8, FMT_U8, FMT_I4, FMT_U4};

    tcu_fedp_unit DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .valid_in  (valid_in),
        .fmt       (fmt),
        .a_row     (a_row),
        .b_col     (b_col),
        .c_val     (c_val),
        .valid_out (valid_out),
        .d_val     (d_val)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // lane by lane dot product plus c modulo 2^32
    function automatic word_t fedp_ref(input int_fmt_e f, input word_t [NUM_LANES-1:0] a,
                                       input word_t [NUM_LANES-1:0] b, input word_t c);
        int     w;
        bit     is_signed;
        longint mask;
        longint la;
        longint lb;
        longint sum;
        w = (f == FMT_I8 || f == FMT_U8) ? 8 : 4;
        is_signed = (f == FMT_I8 || f == FMT_I4);
        mask = (longint'(1) << w) - 1;
        sum = longint'(c);
        for (int i = 0; i < NUM_LANES; i++) begin
            for (int k = 0; k < 32 / w; k++) begin
                la = longint'(a[i] >> (k * w)) & mask;
                lb = longint'(b[i] >> (k * w)) & mask;
                if (is_signed && la >= (longint'(1) << (w - 1))) begin
                    la = la - (longint'(1) << w);
                end
                if (is_signed && lb >= (longint'(1) << (w - 1))) begin
                    lb = lb - (longint'(1) << w);
                end
                sum = sum + la * lb;
            end
        end
        return word_t'(sum);
    endfunction

    task automatic check_dval(input word_t exp_val, input word_t act_val);
        if (act_val !== exp_val) begin
            $display("MISMATCH at %0t: d_val expected %08h got %08h", $time, exp_val, act_val);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_valid(input logic exp_val);
        if (valid_out !== exp_val) begin
            $display("MISMATCH at %0t: valid_out expected %b got %b", $time, exp_val, valid_out);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // a result leaves the output stage on an enabled edge
    always @(posedge clk) begin
        if (rst_n && enable && valid_out) begin
            if (expected_q.size() == 0) begin
                $display("ERROR at %0t: valid_out high with no request in flight", $time);
                fail_count++;
            end else begin
                check_dval(expected_q.pop_front(), d_val);
            end
        end
        if (rst_n && enable && valid_in) begin
            expected_q.push_back(fedp_ref(fmt, a_row, b_col, c_val));
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("ERROR: timeout after %0d cycles with %0d results pending",
                     cycle_count, expected_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic drive(input logic vld, input logic en, input int_fmt_e f,
                         input word_t [NUM_LANES-1:0] a, input word_t [NUM_LANES-1:0] b,
                         input word_t c);
        @(negedge clk);
        valid_in = vld;
        enable   = en;
        fmt      = f;
        a_row    = a;
        b_col    = b;
        c_val    = c;
    endtask

    // fmt stays legal so the delayed select is never junk
    task automatic idle();
        drive(1'b0, 1'b1, FMT_I8, '0, '0, '0);
    endtask

    task automatic send_random(input int_fmt_e f, input logic en);
        word_t [NUM_LANES-1:0] a;
        word_t [NUM_LANES-1:0] b;
        for (int i = 0; i < NUM_LANES; i++) begin
            a[i] = lcg_next();
            b[i] = lcg_next();
        end
        drive(1'b1, en, f, a, b, lcg_next());
    endtask

    task automatic send_fixed(input int_fmt_e f, input word_t aw, input word_t bw,
                              input word_t c);
        drive(1'b1, 1'b1, f, {NUM_LANES{aw}}, {NUM_LANES{bw}}, c);
    endtask

    // with enable high every result is out within the pipeline depth
    task automatic drain();
        int waited;
        waited = 0;
        idle();
        while (expected_q.size() != 0 && waited <= FEDP_LATENCY) begin
            idle();
            waited++;
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %-8s done, %0d errors", name, fail_count - fails_before);
    endtask

    initial begin
        int       fails_before;
        int       accepted;
        logic     en;
        int_fmt_e f;
        rst_n    = 1'b0;
        enable   = 1'b1;
        valid_in = 1'b0;
        fmt      = FMT_I8;
        a_row    = '0;
        b_col    = '0;
        c_val    = '0;

        fails_before = fail_count;
        repeat (2) begin
            @(negedge clk);
            check_valid(1'b0);
        end
        rst_n = 1'b1;
        repeat (FEDP_LATENCY) begin
            idle();
            check_valid(1'b0);
        end
        report_test("reset", fails_before);

        fails_before = fail_count;
        foreach (fmt_list[j]) begin
            repeat (NUM_PER_FMT) begin
                send_random(fmt_list[j], 1'b1);
            end
        end
        drain();
        report_test("formats", fails_before);

        // minimum signed, maximum unsigned, c near 2^31 and past 2^32
        fails_before = fail_count;
        send_fixed(FMT_I8, 32'h8080_8080, 32'h8080_8080, 32'h0000_0000);
        send_fixed(FMT_I4, 32'h8888_8888, 32'h8888_8888, 32'h0000_0000);
        send_fixed(FMT_U8, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000);
        send_fixed(FMT_U4, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000);
        send_fixed(FMT_I8, 32'h8080_8080, 32'h7f7f_7f7f, 32'h8000_0000);
        send_fixed(FMT_U8, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fff0);
        send_fixed(FMT_I4, 32'h8888_8888, 32'h7777_7777, 32'h7fff_fff8);
        drain();
        report_test("extremes", fails_before);

        fails_before = fail_count;
        send_random(FMT_U8, 1'b1);
        for (int k = 1; k <= FEDP_LATENCY + 1; k++) begin
            idle();
            check_valid(k == FEDP_LATENCY);
        end
        drain();
        report_test("latency", fails_before);

        // enable low about 30% of the edges
        fails_before = fail_count;
        accepted = 0;
        while (accepted < NUM_STALL_REQ) begin
            en = ((lcg_next() >> 16) % 10) >= 3;
            f = int_fmt_e'(1 + (lcg_next() >> 16) % 4);
            send_random(f, en);
            if (en) begin
                accepted++;
            end
        end
        drain();
        report_test("stall", fails_before);

        if (expected_q.size() != 0) begin
            $display("ERROR: %0d expected results were never delivered", expected_q.size());
            fail_count++;
        end
        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tcu_fedp_unit.sv
`timescale 1ns/1ns

module tcu_fedp_unit (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      enable,
    input  logic                                      valid_in,
    input  tcu_pkg::int_fmt_e                         fmt,
    input  tcu_pkg::word_t [tcu_pkg::NUM_LANES-1:0]   a_row,
    input  tcu_pkg::word_t [tcu_pkg::NUM_LANES-1:0]   b_col,
    input  tcu_pkg::word_t                            c_val,
    output logic                                      valid_out,
    output tcu_pkg::word_t                            d_val
);
    import tcu_pkg::*;

    fedp_req_if req ();

    // request bundle straight from the pins
    assign req.fmt   = fmt;
    assign req.a_row = a_row;
    assign req.b_col = b_col;
    assign req.c_val = c_val;

    fedp_int u_fedp (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .req    (req.dst),
        .d_val  (d_val)
    );

    // valid marks results, same stalls as the datapath
    pipe_register #(
        .DATAW (1),
        .DEPTH (FEDP_LATENCY)
    ) u_valid_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .data_in  (valid_in),
        .data_out (valid_out)
    );

    valid_fmt_legal_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_in |-> fmt inside {FMT_I8, FMT_U8, FMT_I4, FMT_U4}
    );

endmodule

// File: tcu_pkg.sv
package tcu_pkg;

    // lane packing of an operand word
    typedef enum logic [2:0] {
        FMT_I8 = 3'd1,
        FMT_U8 = 3'd2,
        FMT_I4 = 3'd3,
        FMT_U4 = 3'd4
    } int_fmt_e;

    // one operand or result word
    typedef logic [31:0] word_t;

    // words per row and per column, must be a power of two
    localparam int NUM_LANES = 4;

    // adder tree depth
    localparam int LEVELS = $clog2(NUM_LANES);

    // largest per-word sum is 18 bits, one more for the guard bit
    localparam int PROD_W = 19;

    // tree grows one bit per level
    localparam int RED_W = PROD_W + LEVELS;

    // multiply stage, then one register per tree level
    localparam int MUL_LATENCY = 2;
    localparam int ADD_LATENCY = 1;
    localparam int RED_LATENCY = LEVELS * ADD_LATENCY;

    // request to d_val, accumulate included
    localparam int FEDP_LATENCY = MUL_LATENCY + RED_LATENCY + ADD_LATENCY;

endpackage
